// ==== project.f ====
verilog/pll_pkg.sv
verilog/pll_cfg_if.sv
verilog/pll_apb_regs.sv
verilog/pll_startup_lock.sv
verilog/pll_ssc_mod.sv
verilog/pll_postscaler.sv
verilog/pll_ctrl_top.sv
sim/tb_pll_ctrl.sv

// ==== Bender.yml ====
package:
  name: pll_ctrl

sources:
  - verilog/pll_pkg.sv
  - verilog/pll_cfg_if.sv
  - verilog/pll_apb_regs.sv
  - verilog/pll_startup_lock.sv
  - verilog/pll_ssc_mod.sv
  - verilog/pll_postscaler.sv
  - verilog/pll_ctrl_top.sv
  - target: simulation
    files:
      - sim/tb_pll_ctrl.sv

// ==== sim/tb_pll_ctrl.sv ====
/*
 * Testbench for the PLL controller. Random APB traffic from a fixed seed,
 * timing and multiplier checks against a cycle model kept in the testbench.
 */
`timescale 1ns/1ns

module tb_pll_ctrl import pll_pkg::*; ();

  logic              clk_ref;
  logic              int_rst_n;
  logic [apb_aw-1:0] paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [apb_dw-1:0] pwdata;
  logic [apb_dw-1:0] prdata;
  logic              pready;
  logic              pslverr;
  logic              locked;
  logic [mult_w-1:0] mult_word;
  logic              ps0_tick;
  logic              ps1_tick;

  int                n_checks;
  int                n_errors;
  int                n_timeouts;
  int unsigned       cyc;          // Edges since reset release
  integer            seed;
  logic [apb_dw-1:0] shadow [0:4]; // Expected read-back, index addr/4
  logic [apb_dw-1:0] rd;
  logic [apb_dw-1:0] wd;
  logic [apb_dw-1:0] mul;
  logic [mult_w-1:0] base;
  logic [mult_w-1:0] exp_word;
  logic [16:0]       acc;          // Model triangle
  logic              up;
  int                rc, at, i, k, g, shift, lock_t, step, period, cnt;
  int                l1a, l2a, l1b, l2b, p0, p1;

  pll_ctrl_top u_dut (.*);

  always #4 clk_ref = ~clk_ref;  // 8 ns period

  always @(posedge clk_ref) begin
    if (!int_rst_n) cyc <= 0;
    else            cyc <= cyc + 1;
  end

  task automatic check_equal(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_ref);
    #1;
  endtask

  // One APB transfer, called 1 ns after an edge and returns the same way
  task automatic apb_xfer(input logic wr, input logic [apb_aw-1:0] addr,
                          input logic [apb_dw-1:0] data, input logic exp_err,
                          output logic [apb_dw-1:0] rdata, output int at_cyc);
    int n;
    n       = 0;
    psel    = 1'b1;  // Setup phase
    paddr   = addr;
    pwrite  = wr;
    pwdata  = data;
    @(posedge clk_ref);
    #1 penable = 1'b1;
    #3;              // Middle of access phase
    while (!pready && n < 16) begin
      @(posedge clk_ref);
      #4;
      n++;
    end
    if (!pready) begin
      n_timeouts++;
      $display("timeout: APB transfer to address %0h never completed", addr);
    end
    check_equal("apb wait states", n, 0);  // pready high in the first access cycle
    rdata  = prdata;
    at_cyc = cyc;
    check_equal("pslverr", pslverr, exp_err);
    next_cycle();    // Edge that closes the access phase
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic wait_locked(output int at_cyc);
    int n;
    n = 0;
    while (locked !== 1'b1 && n < 20000) begin
      next_cycle();
      n++;
    end
    if (locked !== 1'b1) begin
      n_timeouts++;
      $display("timeout: locked never rose");
    end
    at_cyc = cyc;
  endtask

  function automatic logic [apb_dw-1:0] field(input int lsb, input int w);
    return ((32'd1 << w) - 1) << lsb;
  endfunction

  // Bits that a register stores and reads back
  function automatic logic [apb_dw-1:0] reg_mask(input logic [apb_aw-1:0] addr);
    logic [apb_dw-1:0] m;
    m = '0;
    case (addr)
      addr_ctrl: m = field(ctrl_int_mode_bit, 1) | field(ctrl_ssc_en_bit, 1) |
                     field(ctrl_ps0_en_bit, 1) | field(ctrl_ps1_en_bit, 1);
      addr_mul:  m = field(mul_frac_lsb, mul_frac_w) | field(mul_int_lsb, mul_int_w);
      addr_ssc:  m = field(ssc_step_lsb, ssc_step_w) | field(ssc_period_lsb, ssc_period_w);
      addr_ldet: m = field(ldet_shift_lsb, ld_shift_w) | field(ldet_lock_en_bit, 1) |
                     field(ldet_force_bit, 1);
      addr_ps:   m = field(ps0_l1_lsb, ps_l1_w) | field(ps0_l2_lsb, ps_l2_w) |
                     field(ps1_l1_lsb, ps_l1_w) | field(ps1_l2_lsb, ps_l2_w);
      default:   m = '0;
    endcase
    return m;
  endfunction

  // Multiplier word without modulation
  function automatic logic [mult_w-1:0] base_word(input logic [apb_dw-1:0] mul_reg,
                                                  input logic int_mode);
    logic [mult_w-1:0] w_int;
    logic [mult_w-1:0] w_frac;
    w_int  = (mul_reg >> mul_int_lsb) & field(0, mul_int_w);
    w_frac = int_mode ? '0 : (mul_reg >> mul_frac_lsb) & field(0, mul_frac_w);
    return (w_int << (mult_w - mul_int_w)) | (w_frac << (mult_w - mul_int_w - mul_frac_w));
  endfunction

  initial begin
    seed       = 32'ha777_a47e;
    clk_ref    = 1'b0;
    int_rst_n  = 1'b0;
    paddr      = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    pwdata     = '0;
    n_checks   = 0;
    n_errors   = 0;
    n_timeouts = 0;
    repeat (5) @(posedge clk_ref);
    #1 int_rst_n = 1'b1;
    check_equal("locked", locked, 1'b0);  // Reset values
    check_equal("ps0_tick", ps0_tick, 1'b0);
    check_equal("ps1_tick", ps1_tick, 1'b0);
    check_equal("pslverr", pslverr, 1'b0);

    // ============================================================
    // Register access, runs inside the calibration wait
    // ============================================================
    for (k = 0; k < 2; k++) begin
      for (i = 0; i < 5; i++) begin
        wd = $random(seed);
        apb_xfer(1'b1, apb_aw'(i * 4), wd, 1'b0, rd, rc);
        shadow[i] = wd & reg_mask(apb_aw'(i * 4));
      end
      for (i = 0; i < 5; i++) begin
        apb_xfer(1'b0, apb_aw'(i * 4), '0, 1'b0, rd, rc);
        check_equal("prdata", rd, shadow[i]);
      end
    end
    wd = $random(seed);
    apb_xfer(1'b1, 8'h18 + (wd[7:0] & 8'h7C), wd, 1'b1, rd, rc);  // Unmapped
    apb_xfer(1'b1, addr_status, '1, 1'b1, rd, rc);                 // Read only
    for (i = 0; i < 5; i++) begin
      apb_xfer(1'b0, apb_aw'(i * 4), '0, 1'b0, rd, rc);
      check_equal("prdata", rd, shadow[i]);  // Untouched by the errors
    end

    // ============================================================
    // Startup and lock timing
    // ============================================================
    shift = $random(seed) & 7;
    apb_xfer(1'b1, addr_ldet, field(ldet_lock_en_bit, 1) | (shift << ldet_shift_lsb),
             1'b0, rd, rc);
    apb_xfer(1'b1, addr_ctrl, '0, 1'b0, rd, rc);
    g = 0;
    i = 0;
    while (!g && i < startup_cycles) begin
      apb_xfer(1'b0, addr_status, '0, 1'b0, rd, rc);
      check_equal("status", rd, (rc >= startup_cycles) ? field(status_running_bit, 1) : '0);
      g = rd[status_running_bit];
      i++;
    end
    if (!g) begin
      n_timeouts++;
      $display("timeout: running never rose");
    end
    lock_t = ld_base_cycles << shift;
    wait_locked(at);
    check_equal("locked rise cycle", at, startup_cycles + lock_t + 1);
    apb_xfer(1'b0, addr_status, '0, 1'b0, rd, rc);
    check_equal("status", rd, field(status_running_bit, 1) | field(status_locked_bit, 1));

    // MUL write with SSC off restarts the lock search
    mul = $random(seed);
    apb_xfer(1'b1, addr_mul, mul, 1'b0, rd, rc);
    rc = cyc;  // Completion edge
    check_equal("locked", locked, 1'b0);
    next_cycle();
    check_equal("mult_word", mult_word, base_word(mul, 1'b0));
    // force overrides a detector that is still counting
    apb_xfer(1'b1, addr_ldet, (shift << ldet_shift_lsb) | field(ldet_force_bit, 1),
             1'b0, rd, at);
    check_equal("locked", locked, 1'b1);
    apb_xfer(1'b1, addr_ldet, (shift << ldet_shift_lsb) | field(ldet_lock_en_bit, 1),
             1'b0, rd, at);
    check_equal("locked", locked, 1'b0);
    wait_locked(at);
    check_equal("locked rise cycle", at, rc + lock_t + 1);
    apb_xfer(1'b1, addr_ctrl, field(ctrl_int_mode_bit, 1), 1'b0, rd, rc);
    next_cycle();
    check_equal("mult_word", mult_word, base_word(mul, 1'b1));  // Fraction dropped

    // lock_en in bit 0 of g, force in bit 1
    for (g = 0; g < 4; g++) begin
      apb_xfer(1'b1, addr_ldet, (shift << ldet_shift_lsb) | ((g & 1) << ldet_lock_en_bit) |
               ((g >> 1) << ldet_force_bit), 1'b0, rd, rc);
      check_equal("locked", locked, g != 0);
    end

    // ============================================================
    // SSC triangle
    // ============================================================
    step   = $random(seed) & 8'hFF;
    period = 1 + ($random(seed) & 7);
    apb_xfer(1'b1, addr_ssc, (step << ssc_step_lsb) | (period << ssc_period_lsb),
             1'b0, rd, rc);
    apb_xfer(1'b1, addr_ctrl, field(ctrl_ssc_en_bit, 1), 1'b0, rd, rc);
    base = base_word(mul, 1'b0);
    acc  = '0;
    up   = 1'b1;
    cnt  = 1;
    for (k = 0; k < 4 * period + 4; k++) begin
      next_cycle();
      exp_word = base + mult_w'(acc);  // Word lags the triangle by one
      check_equal("mult_word", mult_word, exp_word);
      acc = up ? acc + step : acc - step;
      if (cnt == period) begin
        cnt = 1;
        up  = !up;  // Direction flip
      end else begin
        cnt++;
      end
    end
    apb_xfer(1'b1, addr_ctrl, '0, 1'b0, rd, rc);

    // ============================================================
    // Postscalers
    // ============================================================
    for (g = 0; g < 2; g++) begin
      l1a = $random(seed) & 3;
      l2a = $random(seed) & 31;
      l1b = $random(seed) & 3;
      l2b = $random(seed) & 31;
      apb_xfer(1'b1, addr_ps, (l1a << ps0_l1_lsb) | (l2a << ps0_l2_lsb) |
               (l1b << ps1_l1_lsb) | (l2b << ps1_l2_lsb), 1'b0, rd, rc);
      apb_xfer(1'b1, addr_ctrl, field(ctrl_ps0_en_bit, 1) | field(ctrl_ps1_en_bit, 1),
               1'b0, rd, rc);
      p0 = (1 << l1a) * ((l2a == 0) ? 1 : l2a);  // Zero L2 divides by one
      p1 = (1 << l1b) * ((l2b == 0) ? 1 : l2b);
      for (k = 1; k <= 2 * ((p0 > p1) ? p0 : p1) + 2; k++) begin
        next_cycle();
        check_equal("ps0_tick", ps0_tick, (k % p0) == 0);
        check_equal("ps1_tick", ps1_tick, (k % p1) == 0);
      end
      apb_xfer(1'b1, addr_ctrl, '0, 1'b0, rd, rc);
      for (k = 0; k < 16; k++) begin
        next_cycle();
        check_equal("ps0_tick", ps0_tick, 1'b0);  // Quiet while disabled
        check_equal("ps1_tick", ps1_tick, 1'b0);
      end
    end

    $display("checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
    if (n_errors == 0 && n_timeouts == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog/pll_ctrl_top.sv ====
/*
 * Top level of the PLL controller. APB and status on plain ports, the
 * configuration travels to the function blocks over pll_cfg_if.
 */
`timescale 1ns/1ns

module pll_ctrl_top import pll_pkg::*; (
  input  logic              clk_ref,
  input  logic              int_rst_n,
  // APB slave
  input  logic [apb_aw-1:0] paddr,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [apb_dw-1:0] pwdata,
  output logic [apb_dw-1:0] prdata,
  output logic              pready,
  output logic              pslverr,
  // PLL status and control outputs
  output logic              locked,
  output logic [mult_w-1:0] mult_word,
  output logic              ps0_tick,
  output logic              ps1_tick
);

  logic running;     // Calibration done
  logic locked_raw;  // Lock before enable and force

  pll_cfg_if cfg ();

  pll_apb_regs u_regs (
    .clk_ref   (clk_ref),
    .int_rst_n (int_rst_n),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .cfg       (cfg.regs),
    .running   (running),
    .locked    (locked)
  );

  pll_startup_lock u_lock (
    .clk_ref    (clk_ref),
    .int_rst_n  (int_rst_n),
    .cfg        (cfg.sink),
    .running    (running),
    .locked_raw (locked_raw),
    .locked     (locked)
  );

  pll_ssc_mod u_ssc (
    .clk_ref    (clk_ref),
    .int_rst_n  (int_rst_n),
    .cfg        (cfg.sink),
    .locked_raw (locked_raw),
    .mult_word  (mult_word)
  );

  // ============================================================
  // Postscalers, one per output
  // ============================================================
  pll_postscaler u_ps0 (
    .clk_ref   (clk_ref),
    .int_rst_n (int_rst_n),
    .en        (cfg.ps0_en),
    .running   (running),
    .l1        (cfg.ps0_l1),
    .l2        (cfg.ps0_l2),
    .tick      (ps0_tick)
  );

  pll_postscaler u_ps1 (
    .clk_ref   (clk_ref),
    .int_rst_n (int_rst_n),
    .en        (cfg.ps1_en),
    .running   (running),
    .l1        (cfg.ps1_l1),
    .l2        (cfg.ps1_l2),
    .tick      (ps1_tick)
  );

endmodule

// ==== verilog/pll_postscaler.sv ====
/*
 * Output postscaler. A 2**l1 prescale feeds an l2 down-counter and tick
 * pulses for one cycle each 2**l1 * max(l2,1) cycles while active.
 */
`timescale 1ns/1ns

module pll_postscaler import pll_pkg::*; (
  input  logic               clk_ref,
  input  logic               int_rst_n,
  input  logic               en,
  input  logic               running,
  input  logic [ps_l1_w-1:0] l1,
  input  logic [ps_l2_w-1:0] l2,
  output logic               tick
);

  logic [ps_pre_w-1:0] pre_cnt;   // Prescale position
  logic [ps_pre_w-1:0] pre_last;  // 2**l1 - 1
  logic                pre_wrap;
  logic [ps_l2_w-1:0]  l2_cnt;    // Counts down to zero
  logic [ps_l2_w-1:0]  l2_load;
  logic                active;

  assign active   = en & running;
  assign pre_last = ps_pre_w'((1 << l1) - 1);
  assign pre_wrap = (pre_cnt == pre_last);
  assign l2_load  = (l2 == '0) ? '0 : l2 - 1'b1;  // Zero behaves as one

  // ============================================================
  // Divider chain
  // ============================================================
  always_ff @(posedge clk_ref) begin
    if (!int_rst_n || !active) begin
      pre_cnt <= '0;
      l2_cnt  <= l2_load;  // First tick a full period after enable
      tick    <= 1'b0;
    end else begin
      pre_cnt <= pre_wrap ? '0 : pre_cnt + 1'b1;
      tick    <= pre_wrap && (l2_cnt == '0);
      if (pre_wrap) begin
        l2_cnt <= (l2_cnt == '0) ? l2_load : l2_cnt - 1'b1;
      end
    end
  end

  // Back-to-back ticks only for a total divide of one
  a_tick_gap: assert property (@(posedge clk_ref) disable iff (!int_rst_n)
    (tick && !((l1 == '0) && (l2 <= ps_l2_w'(1)))) |=> !tick);

endmodule

// ==== verilog/pll_ssc_mod.sv ====
/*
 * Spread-spectrum modulator. A triangle accumulator is added to the
 * programmed ratio to form the registered feedback multiplier word.
 */
`timescale 1ns/1ns

module pll_ssc_mod import pll_pkg::*; (
  input  logic              clk_ref,
  input  logic              int_rst_n,
  pll_cfg_if.sink           cfg,
  input  logic              locked_raw,
  output logic [mult_w-1:0] mult_word
);

  logic [ssc_acc_w-1:0]    ssc_acc;       // Triangle value
  logic [ssc_period_w-1:0] ssc_step_cnt;  // Position in half period
  logic                    ssc_up;        // 1 = ramp up
  logic                    ssc_hold;
  logic [mul_frac_w-1:0]   frac_sel;

  // Modulation only runs once locked with SSC on
  assign ssc_hold = ~cfg.ssc_en | ~locked_raw;

  // ============================================================
  // Triangle accumulator
  // ============================================================
  always_ff @(posedge clk_ref) begin
    if (!int_rst_n || ssc_hold) begin
      ssc_acc      <= '0;
      ssc_up       <= 1'b1;
      ssc_step_cnt <= ssc_period_w'(1);
    end else begin
      if (ssc_step_cnt == cfg.ssc_period) begin
        ssc_step_cnt <= ssc_period_w'(1);
        ssc_up       <= ~ssc_up;  // Turn at end of half period
      end else begin
        ssc_step_cnt <= ssc_step_cnt + 1'b1;
      end
      ssc_acc <= ssc_up ? ssc_acc + ssc_acc_w'(cfg.ssc_step)
                        : ssc_acc - ssc_acc_w'(cfg.ssc_step);
    end
  end

  // ============================================================
  // Full multiplier word
  // ============================================================
  assign frac_sel = cfg.integer_mode ? '0 : cfg.mul_frac;

  // int | frac | guard zeros, plus modulation in the low bits
  always_ff @(posedge clk_ref) begin
    mult_word <= {cfg.mul_int, frac_sel, {(mult_w - mul_int_w - mul_frac_w){1'b0}}}
                 + mult_w'(ssc_acc);
  end

  // A held modulator adds nothing, so the guard bits of the word read zero
  a_acc_cleared: assert property (@(posedge clk_ref) disable iff (!int_rst_n)
    ssc_hold [*2] |=> (mult_word[mult_w-mul_int_w-mul_frac_w-1:0] == '0));

endmodule

// ==== verilog/pll_startup_lock.sv ====
/*
 * Startup calibration wait and lock detector. running rises after the
 * calibration count, then a countdown of base << shift cycles sets lock.
 */
`timescale 1ns/1ns

module pll_startup_lock import pll_pkg::*; (
  input  logic    clk_ref,
  input  logic    int_rst_n,
  pll_cfg_if.sink cfg,
  output logic    running,
  output logic    locked_raw,
  output logic    locked
);

  logic [startup_cnt_w-1:0] cal_cnt;  // Calibration cycles seen
  logic [ld_cnt_w-1:0]      ld_cnt;   // Lock countdown
  logic [ld_cnt_w-1:0]      ld_time;
  logic                     ld_reload;

  // ============================================================
  // Startup calibration
  // ============================================================
  always_ff @(posedge clk_ref) begin
    if (!int_rst_n) begin
      cal_cnt <= '0;
      running <= 1'b0;
    end else if (!running) begin
      cal_cnt <= cal_cnt + 1'b1;
      // Last count, running high on the startup_cycles-th edge
      if (cal_cnt == startup_cnt_w'(startup_cycles - 1)) begin
        running <= 1'b1;
      end
    end
  end

  // ============================================================
  // Lock detector
  // ============================================================
  assign ld_time = ld_cnt_w'(ld_base_cycles) << cfg.ld_shift;

  // Ratio change with a fixed frequency restarts the lock search
  assign ld_reload = ~running | (cfg.mul_wr & ~cfg.ssc_en);

  always_ff @(posedge clk_ref) begin
    if (!int_rst_n) begin
      ld_cnt     <= '0;
      locked_raw <= 1'b0;
    end else if (ld_reload) begin
      ld_cnt     <= ld_time;  // Tracks shift while idle
      locked_raw <= 1'b0;
    end else begin
      if (ld_cnt == '0) begin
        locked_raw <= 1'b1;  // One cycle after reaching zero
      end
      ld_cnt <= locked_raw ? ld_time : ld_cnt - 1'b1;
    end
  end

  // Enable and force gating, no extra delay
  assign locked = (locked_raw & cfg.ld_lock_en) | cfg.ld_force;

  // Lock is only gained after calibration has finished
  a_lock_after_run: assert property (@(posedge clk_ref) disable iff (!int_rst_n)
    $rose(locked_raw) |-> running);

endmodule

// ==== verilog/pll_apb_regs.sv ====
/*
 * APB slave for the PLL controller. Zero wait states, writes land at the
 * edge that closes the access phase, STATUS is read only.
 */
`timescale 1ns/1ns

module pll_apb_regs import pll_pkg::*; (
  input  logic              clk_ref,
  input  logic              int_rst_n,
  input  logic [apb_aw-1:0] paddr,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [apb_dw-1:0] pwdata,
  output logic [apb_dw-1:0] prdata,
  output logic              pready,
  output logic              pslverr,
  pll_cfg_if.regs           cfg,
  input  logic              running,
  input  logic              locked
);

  logic access;    // Access phase
  logic addr_hit;  // Address inside the map
  logic wr_en;

  // ============================================================
  // Decode
  // ============================================================
  assign access   = psel & penable;
  assign addr_hit = (paddr == addr_ctrl) || (paddr == addr_mul)  ||
                    (paddr == addr_ssc)  || (paddr == addr_ldet) ||
                    (paddr == addr_ps)   || (paddr == addr_status);

  assign pready  = 1'b1;  // Never stalls
  assign pslverr = access & (~addr_hit | (pwrite & (paddr == addr_status)));
  assign wr_en   = access & pwrite & ~pslverr;

  // Reload pulse for the lock detector
  assign cfg.mul_wr = wr_en & (paddr == addr_mul);

  // ============================================================
  // Register writes
  // ============================================================
  always_ff @(posedge clk_ref) begin
    if (!int_rst_n) begin
      cfg.integer_mode <= 1'b0;
      cfg.ssc_en       <= 1'b0;
      cfg.ps0_en       <= 1'b0;
      cfg.ps1_en       <= 1'b0;
      cfg.mul_int      <= '0;
      cfg.mul_frac     <= '0;
      cfg.ssc_step     <= '0;
      cfg.ssc_period   <= '0;
      cfg.ld_shift     <= '0;
      cfg.ld_lock_en   <= 1'b0;  // Locked stays low until enabled
      cfg.ld_force     <= 1'b0;
      cfg.ps0_l1       <= '0;
      cfg.ps0_l2       <= '0;
      cfg.ps1_l1       <= '0;
      cfg.ps1_l2       <= '0;
    end else if (wr_en) begin
      case (paddr)
        addr_ctrl: begin
          cfg.integer_mode <= pwdata[ctrl_int_mode_bit];
          cfg.ssc_en       <= pwdata[ctrl_ssc_en_bit];
          cfg.ps0_en       <= pwdata[ctrl_ps0_en_bit];
          cfg.ps1_en       <= pwdata[ctrl_ps1_en_bit];
        end
        addr_mul: begin
          cfg.mul_frac <= pwdata[mul_frac_lsb +: mul_frac_w];
          cfg.mul_int  <= pwdata[mul_int_lsb +: mul_int_w];
        end
        addr_ssc: begin
          cfg.ssc_step   <= pwdata[ssc_step_lsb +: ssc_step_w];
          cfg.ssc_period <= pwdata[ssc_period_lsb +: ssc_period_w];
        end
        addr_ldet: begin
          cfg.ld_shift   <= pwdata[ldet_shift_lsb +: ld_shift_w];
          cfg.ld_lock_en <= pwdata[ldet_lock_en_bit];
          cfg.ld_force   <= pwdata[ldet_force_bit];
        end
        addr_ps: begin
          cfg.ps0_l1 <= pwdata[ps0_l1_lsb +: ps_l1_w];
          cfg.ps0_l2 <= pwdata[ps0_l2_lsb +: ps_l2_w];
          cfg.ps1_l1 <= pwdata[ps1_l1_lsb +: ps_l1_w];
          cfg.ps1_l2 <= pwdata[ps1_l2_lsb +: ps_l2_w];
        end
        default: ;  // STATUS and misses filtered by wr_en
      endcase
    end
  end

  // Read-back mux, unused bits read zero
  always_comb begin
    prdata = '0;
    case (paddr)
      addr_ctrl: begin
        prdata[ctrl_int_mode_bit] = cfg.integer_mode;
        prdata[ctrl_ssc_en_bit]   = cfg.ssc_en;
        prdata[ctrl_ps0_en_bit]   = cfg.ps0_en;
        prdata[ctrl_ps1_en_bit]   = cfg.ps1_en;
      end
      addr_mul: begin
        prdata[mul_frac_lsb +: mul_frac_w] = cfg.mul_frac;
        prdata[mul_int_lsb +: mul_int_w]   = cfg.mul_int;
      end
      addr_ssc: begin
        prdata[ssc_step_lsb +: ssc_step_w]     = cfg.ssc_step;
        prdata[ssc_period_lsb +: ssc_period_w] = cfg.ssc_period;
      end
      addr_ldet: begin
        prdata[ldet_shift_lsb +: ld_shift_w] = cfg.ld_shift;
        prdata[ldet_lock_en_bit]             = cfg.ld_lock_en;
        prdata[ldet_force_bit]               = cfg.ld_force;
      end
      addr_ps: begin
        prdata[ps0_l1_lsb +: ps_l1_w] = cfg.ps0_l1;
        prdata[ps0_l2_lsb +: ps_l2_w] = cfg.ps0_l2;
        prdata[ps1_l1_lsb +: ps_l1_w] = cfg.ps1_l1;
        prdata[ps1_l2_lsb +: ps_l2_w] = cfg.ps1_l2;
      end
      addr_status: begin
        prdata[status_locked_bit]  = locked;
        prdata[status_running_bit] = running;
      end
      default: ;
    endcase
  end

  // Read data must be clean whenever the master samples it
  a_rdata_known: assert property (@(posedge clk_ref) disable iff (!int_rst_n)
    (access && !pwrite) |-> !$isunknown(prdata));

  // APB protocol, access phase only inside a selected transfer
  a_penable_psel: assert property (@(posedge clk_ref) disable iff (!int_rst_n)
    penable |-> psel);

endmodule

// ==== verilog/pll_cfg_if.sv ====
/*
 * Decoded configuration from the APB register block to the lock,
 * SSC and postscaler blocks. regs drives, sink reads.
 */
`timescale 1ns/1ns

interface pll_cfg_if import pll_pkg::*; ();
  logic                    integer_mode;  // Fraction ignored when set
  logic                    ssc_en;
  logic                    ps0_en;
  logic                    ps1_en;
  logic [mul_int_w-1:0]    mul_int;
  logic [mul_frac_w-1:0]   mul_frac;
  logic [ssc_step_w-1:0]   ssc_step;
  logic [ssc_period_w-1:0] ssc_period;
  logic [ld_shift_w-1:0]   ld_shift;      // Lock time = base << shift
  logic                    ld_lock_en;
  logic                    ld_force;
  logic [ps_l1_w-1:0]      ps0_l1;
  logic [ps_l2_w-1:0]      ps0_l2;
  logic [ps_l1_w-1:0]      ps1_l1;
  logic [ps_l2_w-1:0]      ps1_l2;
  logic                    mul_wr;        // Pulse in the MUL write access

  modport regs (output integer_mode, ssc_en, ps0_en, ps1_en, mul_int, mul_frac,
                ssc_step, ssc_period, ld_shift, ld_lock_en, ld_force,
                ps0_l1, ps0_l2, ps1_l1, ps1_l2, mul_wr);

  modport sink (input integer_mode, ssc_en, ps0_en, ps1_en, mul_int, mul_frac,
                ssc_step, ssc_period, ld_shift, ld_lock_en, ld_force,
                ps0_l1, ps0_l2, ps1_l1, ps1_l2, mul_wr);
endinterface

// ==== verilog/pll_pkg.sv ====
/*
 * Shared widths, APB register map, field positions and timing constants
 * for the fractional-N PLL controller. Modules import it in their header.
 */
package pll_pkg;

  // ============================================================
  // Bus and datapath widths
  // ============================================================
  localparam int apb_aw       = 8;   // Byte address
  localparam int apb_dw       = 32;
  localparam int mul_int_w    = 11;  // Integer part of feedback ratio
  localparam int mul_frac_w   = 12;  // Fractional part
  localparam int mult_w       = 28;  // int | frac | 5 guard bits
  localparam int ssc_acc_w    = 17;  // Triangle accumulator
  localparam int ssc_step_w   = 8;
  localparam int ssc_period_w = 11;  // Half period in ref cycles
  localparam int ps_l1_w      = 2;   // Power-of-two select
  localparam int ps_l2_w      = 8;
  localparam int ps_pre_w     = 3;   // Counts up to 2**3 - 1
  localparam int ld_shift_w   = 3;
  localparam int ld_cnt_w     = 15;  // Holds 128 << 7

  // Timing
  localparam int startup_cycles = 512;             // Calibration wait
  localparam int startup_cnt_w  = $clog2(startup_cycles);
  localparam int ld_base_cycles = 128;             // Lock time at shift 0

  // ============================================================
  // Register map
  // ============================================================
  localparam logic [apb_aw-1:0] addr_ctrl   = 8'h00;
  localparam logic [apb_aw-1:0] addr_mul    = 8'h04;
  localparam logic [apb_aw-1:0] addr_ssc    = 8'h08;
  localparam logic [apb_aw-1:0] addr_ldet   = 8'h0C;
  localparam logic [apb_aw-1:0] addr_ps     = 8'h10;
  localparam logic [apb_aw-1:0] addr_status = 8'h14;  // Read only

  // Field positions
  localparam int ctrl_int_mode_bit  = 0;
  localparam int ctrl_ssc_en_bit    = 1;
  localparam int ctrl_ps0_en_bit    = 2;
  localparam int ctrl_ps1_en_bit    = 3;
  localparam int mul_frac_lsb       = 0;
  localparam int mul_int_lsb        = 16;
  localparam int ssc_step_lsb       = 0;
  localparam int ssc_period_lsb     = 16;
  localparam int ldet_shift_lsb     = 0;
  localparam int ldet_lock_en_bit   = 4;
  localparam int ldet_force_bit     = 5;
  localparam int ps0_l1_lsb         = 0;
  localparam int ps0_l2_lsb         = 8;
  localparam int ps1_l1_lsb         = 16;
  localparam int ps1_l2_lsb         = 24;
  localparam int status_locked_bit  = 0;
  localparam int status_running_bit = 1;

endpackage
